/* include/rv_core_cfg.svh */
`ifndef RV_CORE_CFG_SVH
`define RV_CORE_CFG_SVH

////////////////////////////////////////////////////////////////////////////
// core configuration
////////////////////////////////////////////////////////////////////////////

// first fetch address after reset
// must be word aligned
`define RV_PC0 32'h0000_0000

// register, data bus and address bus width
// RV32I only, so fixed at one word
`define RV_XW 32

// number of general purpose registers
// x0 included, RV32E not supported
`define RV_NREG 32

`endif

/* design/rv_isa_pkg.sv */
`include "rv_core_cfg.svh"

package rv_isa_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // instruction encoding
  ////////////////////////////////////////////////////////////////////////////

  // major opcodes of the supported subset
  typedef enum logic [6:0] {
    OPC_LUI    = 7'b0110111,
    OPC_AUIPC  = 7'b0010111,
    OPC_JAL    = 7'b1101111,
    OPC_JALR   = 7'b1100111,
    OPC_BRANCH = 7'b1100011,
    OPC_LOAD   = 7'b0000011,
    OPC_STORE  = 7'b0100011,
    OPC_OP_IMM = 7'b0010011,
    OPC_OP     = 7'b0110011
  } opcode_t;

  // funct3 of OP and OP-IMM
  typedef enum logic [2:0] {
    F3_ADD  = 3'b000,
    F3_SLL  = 3'b001,
    F3_SLT  = 3'b010,
    F3_SLTU = 3'b011,
    F3_XOR  = 3'b100,
    F3_SR   = 3'b101,
    F3_OR   = 3'b110,
    F3_AND  = 3'b111
  } f3_alu_t;

  // funct3 of LOAD and STORE, access size
  typedef enum logic [2:0] {
    F3_B  = 3'b000,
    F3_H  = 3'b001,
    F3_W  = 3'b010,
    F3_BU = 3'b100,
    F3_HU = 3'b101
  } f3_mem_t;

  // funct7, alternate selects SUB and SRA
  typedef enum logic [6:0] {
    F7_BASE = 7'b0000000,
    F7_ALT  = 7'b0100000
  } f7_t;

  // one instruction word, six format views
  typedef union packed {
    struct packed {
      logic [6:0] funct7;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [4:0] rd;
      opcode_t    opcode;
    } r;
    struct packed {
      logic [11:0] imm_11_0;
      logic [4:0]  rs1;
      logic [2:0]  funct3;
      logic [4:0]  rd;
      opcode_t     opcode;
    } i;
    struct packed {
      logic [6:0] imm_11_5;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [4:0] imm_4_0;
      opcode_t    opcode;
    } s;
    struct packed {
      logic       imm_12;
      logic [5:0] imm_10_5;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [3:0] imm_4_1;
      logic       imm_11;
      opcode_t    opcode;
    } b;
    struct packed {
      logic [19:0] imm_31_12;
      logic [4:0]  rd;
      opcode_t     opcode;
    } u;
    struct packed {
      logic       imm_20;
      logic [9:0] imm_10_1;
      logic       imm_11;
      logic [7:0] imm_19_12;
      logic [4:0] rd;
      opcode_t    opcode;
    } j;
  } insn_t;

  ////////////////////////////////////////////////////////////////////////////
  // control signals
  ////////////////////////////////////////////////////////////////////////////

  // alu operation
  typedef enum logic [3:0] {
    ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU,
    ALU_XOR, ALU_SRL, ALU_SRA, ALU_OR, ALU_AND
  } alu_op_t;

  // branch condition
  // conditional codes equal funct3, the two unused codes are NONE and ALWAYS
  typedef enum logic [2:0] {
    BR_EQ     = 3'b000,
    BR_NE     = 3'b001,
    BR_NONE   = 3'b010,
    BR_ALWAYS = 3'b011,
    BR_LT     = 3'b100,
    BR_GE     = 3'b101,
    BR_LTU    = 3'b110,
    BR_GEU    = 3'b111
  } br_op_t;

  // alu operand sources
  typedef enum logic [1:0] {A1_RS1, A1_PC, A1_ZERO} a1_sel_t;
  typedef enum logic {A2_RS2, A2_IMM} a2_sel_t;

  // write-back source
  typedef enum logic [1:0] {WB_NONE, WB_ALU, WB_MEM, WB_PCN} wb_sel_t;

  // load and store kinds
  typedef enum logic [2:0] {LD_NONE, LD_B, LD_BU, LD_H, LD_HU, LD_W} ld_t;
  typedef enum logic [1:0] {ST_NONE, ST_B, ST_H, ST_W} st_t;

  // decoded control word
  typedef struct packed {
    alu_op_t           ao;
    a1_sel_t           a1;
    a2_sel_t           a2;
    br_op_t            br;
    ld_t               ld;
    st_t               st;
    wb_sel_t           wb;
    logic [`RV_XW-1:0] imm;
  } ctl_t;

endpackage

/* design/rv_decoder.sv */
`timescale 1ns/1ps
`include "rv_core_cfg.svh"

module rv_decoder import rv_isa_pkg::*; (
  input  insn_t insn,
  output ctl_t  ctl
);

  ////////////////////////////////////////////////////////////////////////////
  // immediates, sign extended, one per format
  ////////////////////////////////////////////////////////////////////////////

  logic [`RV_XW-1:0] imm_i;
  logic [`RV_XW-1:0] imm_s;
  logic [`RV_XW-1:0] imm_b;
  logic [`RV_XW-1:0] imm_u;
  logic [`RV_XW-1:0] imm_j;
  logic              f7_alt;

  assign imm_i = {{20{insn.i.imm_11_0[11]}}, insn.i.imm_11_0};
  assign imm_s = {{20{insn.s.imm_11_5[6]}}, insn.s.imm_11_5, insn.s.imm_4_0};
  // branch and jump offsets are in halfwords, bit 0 always zero
  assign imm_b = {{19{insn.b.imm_12}}, insn.b.imm_12, insn.b.imm_11,
                  insn.b.imm_10_5, insn.b.imm_4_1, 1'b0};
  assign imm_u = {insn.u.imm_31_12, 12'h000};
  assign imm_j = {{11{insn.j.imm_20}}, insn.j.imm_20, insn.j.imm_19_12,
                  insn.j.imm_11, insn.j.imm_10_1, 1'b0};

  // SUB and SRA(I) marker
  assign f7_alt = (insn.r.funct7 == F7_ALT);

  // funct3 to alu operation, shared by OP and OP-IMM
  function automatic alu_op_t alu_dec(input logic [2:0] f3, input logic sub,
                                      input logic sra);
    case (f3)
      F3_ADD:  alu_dec = sub ? ALU_SUB : ALU_ADD;
      F3_SLL:  alu_dec = ALU_SLL;
      F3_SLT:  alu_dec = ALU_SLT;
      F3_SLTU: alu_dec = ALU_SLTU;
      F3_XOR:  alu_dec = ALU_XOR;
      F3_SR:   alu_dec = sra ? ALU_SRA : ALU_SRL;
      F3_OR:   alu_dec = ALU_OR;
      default: alu_dec = ALU_AND;
    endcase
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // control
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    // defaults, behaves as a no-op
    ctl.ao  = ALU_ADD;
    ctl.a1  = A1_RS1;
    ctl.a2  = A2_RS2;
    ctl.br  = BR_NONE;
    ctl.ld  = LD_NONE;
    ctl.st  = ST_NONE;
    ctl.wb  = WB_NONE;
    ctl.imm = '0;
    case (insn.r.opcode)
      OPC_LUI: begin
        // zero + imm
        ctl.a1  = A1_ZERO;
        ctl.a2  = A2_IMM;
        ctl.wb  = WB_ALU;
        ctl.imm = imm_u;
      end
      OPC_AUIPC: begin
        ctl.a1  = A1_PC;
        ctl.a2  = A2_IMM;
        ctl.wb  = WB_ALU;
        ctl.imm = imm_u;
      end
      OPC_JAL: begin
        // target from alu sum, link is pc + 4
        ctl.a1  = A1_PC;
        ctl.a2  = A2_IMM;
        ctl.br  = BR_ALWAYS;
        ctl.wb  = WB_PCN;
        ctl.imm = imm_j;
      end
      OPC_JALR: begin
        if (insn.i.funct3 == 3'b000) begin
          ctl.a2  = A2_IMM;
          ctl.br  = BR_ALWAYS;
          ctl.wb  = WB_PCN;
          ctl.imm = imm_i;
        end
      end
      OPC_BRANCH: begin
        // funct3 010 and 011 are reserved
        if (insn.b.funct3[2:1] != 2'b01) begin
          ctl.a1  = A1_PC;
          ctl.a2  = A2_IMM;
          ctl.br  = br_op_t'(insn.b.funct3);
          ctl.imm = imm_b;
        end
      end
      OPC_LOAD: begin
        case (insn.i.funct3)
          F3_B:    ctl.ld = LD_B;
          F3_H:    ctl.ld = LD_H;
          F3_W:    ctl.ld = LD_W;
          F3_BU:   ctl.ld = LD_BU;
          F3_HU:   ctl.ld = LD_HU;
          default: ctl.ld = LD_NONE;
        endcase
        if (ctl.ld != LD_NONE) begin
          ctl.a2  = A2_IMM;
          ctl.wb  = WB_MEM;
          ctl.imm = imm_i;
        end
      end
      OPC_STORE: begin
        case (insn.s.funct3)
          F3_B:    ctl.st = ST_B;
          F3_H:    ctl.st = ST_H;
          F3_W:    ctl.st = ST_W;
          default: ctl.st = ST_NONE;
        endcase
        ctl.a2  = A2_IMM;
        ctl.imm = imm_s;
      end
      OPC_OP_IMM: begin
        // imm[11:5] doubles as funct7 for shifts
        ctl.ao  = alu_dec(insn.i.funct3, 1'b0, f7_alt);
        ctl.a2  = A2_IMM;
        ctl.wb  = WB_ALU;
        ctl.imm = imm_i;
      end
      OPC_OP: begin
        if ((insn.r.funct7 == F7_BASE) || f7_alt) begin
          ctl.ao = alu_dec(insn.r.funct3, f7_alt, f7_alt);
          ctl.wb = WB_ALU;
        end
      end
      default: begin
        ctl.wb = WB_NONE;
      end
    endcase
  end

endmodule

/* design/rv_gpr.sv */
`timescale 1ns/1ps
`include "rv_core_cfg.svh"

module rv_gpr (
  input  logic              clk,
  input  logic              rst,
  input  logic [4:0]        a_rs1,
  input  logic [4:0]        a_rs2,
  input  logic [4:0]        a_rd,
  input  logic              e_rd,
  input  logic [`RV_XW-1:0] d_rd,
  output logic [`RV_XW-1:0] d_rs1,
  output logic [`RV_XW-1:0] d_rs2
);

  // register array, x0 entry never written
  logic [`RV_XW-1:0] gpr [`RV_NREG];

  // single write port
  always_ff @(posedge clk, posedge rst) begin
    if (rst) begin
      for (int i = 0; i < `RV_NREG; i++) begin
        gpr[i] <= '0;
      end
    end else if (e_rd && (a_rd != 5'd0)) begin
      gpr[a_rd] <= d_rd;
    end
  end

  // asynchronous reads, x0 reads as zero
  assign d_rs1 = (a_rs1 == 5'd0) ? '0 : gpr[a_rs1];
  assign d_rs2 = (a_rs2 == 5'd0) ? '0 : gpr[a_rs2];

endmodule

/* design/rv_alu.sv */
`timescale 1ns/1ps
`include "rv_core_cfg.svh"

module rv_alu import rv_isa_pkg::*; (
  input  alu_op_t           op,
  input  logic [`RV_XW-1:0] rs1,
  input  logic [`RV_XW-1:0] rs2,
  output logic [`RV_XW-1:0] rd,
  output logic [`RV_XW-1:0] sum
);

  // shift amount, low five bits only
  logic [4:0] shamt;
  logic       lt_s;
  logic       lt_u;

  assign shamt = rs2[4:0];

  // plain adder, also used for branch targets and load/store addresses
  assign sum = rs1 + rs2;

  // compares
  assign lt_s = $signed(rs1) < $signed(rs2);
  assign lt_u = rs1 < rs2;

  always_comb begin
    case (op)
      ALU_ADD:  rd = sum;
      ALU_SUB:  rd = rs1 - rs2;
      ALU_SLL:  rd = rs1 << shamt;
      ALU_SLT:  rd = {{(`RV_XW-1){1'b0}}, lt_s};
      ALU_SLTU: rd = {{(`RV_XW-1){1'b0}}, lt_u};
      ALU_XOR:  rd = rs1 ^ rs2;
      ALU_SRL:  rd = rs1 >> shamt;
      // arithmetic, sign bit fills in
      ALU_SRA:  rd = $unsigned($signed(rs1) >>> shamt);
      ALU_OR:   rd = rs1 | rs2;
      ALU_AND:  rd = rs1 & rs2;
      default:  rd = sum;
    endcase
  end

endmodule

/* design/rv_br.sv */
`timescale 1ns/1ps
`include "rv_core_cfg.svh"

module rv_br import rv_isa_pkg::*; (
  input  br_op_t            op,
  input  logic [`RV_XW-1:0] rs1,
  input  logic [`RV_XW-1:0] rs2,
  output logic              tkn
);

  // branch condition evaluation
  always_comb begin
    case (op)
      BR_EQ:     tkn = (rs1 == rs2);
      BR_NE:     tkn = (rs1 != rs2);
      // signed
      BR_LT:     tkn = ($signed(rs1) < $signed(rs2));
      BR_GE:     tkn = ($signed(rs1) >= $signed(rs2));
      // unsigned
      BR_LTU:    tkn = (rs1 < rs2);
      BR_GEU:    tkn = (rs1 >= rs2);
      // jumps
      BR_ALWAYS: tkn = 1'b1;
      default:   tkn = 1'b0;
    endcase
  end

endmodule

/* design/rv_core.sv */
`timescale 1ns/1ps
`include "rv_core_cfg.svh"

module rv_core import rv_isa_pkg::*; (
  input  logic              clk,
  input  logic              rst,
  // program bus
  output logic              if_req,
  output logic [`RV_XW-1:0] if_adr,
  input  logic [`RV_XW-1:0] if_rdt,
  input  logic              if_ack,
  // data bus
  output logic              ls_req,
  output logic              ls_wen,
  output logic [`RV_XW-1:0] ls_adr,
  output logic [3:0]        ls_sel,
  output logic [`RV_XW-1:0] ls_wdt,
  input  logic [`RV_XW-1:0] ls_rdt,
  input  logic              ls_ack
);

  // sequencer states
  typedef enum logic [1:0] {S_FETCH, S_EXEC, S_MEM} seq_t;

  seq_t              state;
  logic              run;
  logic [`RV_XW-1:0] pc;
  logic [`RV_XW-1:0] pc4;
  logic [`RV_XW-1:0] pcn;
  insn_t             ir;
  ctl_t              ctl;
  logic              mem_op;
  // register file
  logic [`RV_XW-1:0] gpr_rs1;
  logic [`RV_XW-1:0] gpr_rs2;
  logic [`RV_XW-1:0] gpr_rd;
  logic              gpr_we;
  // execute
  logic [`RV_XW-1:0] alu_rs1;
  logic [`RV_XW-1:0] alu_rs2;
  logic [`RV_XW-1:0] alu_rd;
  logic [`RV_XW-1:0] alu_sum;
  logic              br_tkn;
  // load/store lanes
  logic [3:0]        ls_mask;
  logic [7:0]        ld_b;
  logic [15:0]       ld_h;
  logic [`RV_XW-1:0] ld_dat;

  ////////////////////////////////////////////////////////////////////////////
  // fetch sequencer and pc
  ////////////////////////////////////////////////////////////////////////////

  // keeps if_req low through reset, rises one clock after release
  always_ff @(posedge clk, posedge rst) begin
    if (rst) begin
      run <= 1'b0;
    end else begin
      run <= 1'b1;
    end
  end

  assign if_req = run && (state == S_FETCH);
  assign if_adr = pc;

  always_ff @(posedge clk, posedge rst) begin
    if (rst) begin
      state <= S_FETCH;
      pc    <= `RV_PC0;
    end else begin
      case (state)
        S_FETCH: begin
          if (if_req && if_ack) begin
            state <= S_EXEC;
          end
        end
        S_EXEC: begin
          // non-memory insn retires here
          if (mem_op) begin
            state <= S_MEM;
          end else begin
            pc    <= pcn;
            state <= S_FETCH;
          end
        end
        S_MEM: begin
          if (ls_ack) begin
            pc    <= pc4;
            state <= S_FETCH;
          end
        end
        default: state <= S_FETCH;
      endcase
    end
  end

  // instruction register
  always_ff @(posedge clk) begin
    if (if_req && if_ack) begin
      ir <= if_rdt;
    end
  end

  assign pc4 = pc + `RV_XW'd4;
  // bit 0 cleared for JALR, already zero for JAL and branches
  assign pcn = br_tkn ? {alu_sum[`RV_XW-1:1], 1'b0} : pc4;

  ////////////////////////////////////////////////////////////////////////////
  // decode, registers, execute
  ////////////////////////////////////////////////////////////////////////////

  rv_decoder rv_decoder_inst (
    .insn (ir),
    .ctl  (ctl)
  );

  assign mem_op = (ctl.ld != LD_NONE) || (ctl.st != ST_NONE);

  // write in EXEC for alu/link, on ls_ack for loads
  assign gpr_we = ((state == S_EXEC) && !mem_op && (ctl.wb != WB_NONE)) ||
                  ((state == S_MEM) && ls_ack && (ctl.wb == WB_MEM));

  // write-back mux
  always_comb begin
    case (ctl.wb)
      WB_MEM:  gpr_rd = ld_dat;
      WB_PCN:  gpr_rd = pc4;
      default: gpr_rd = alu_rd;
    endcase
  end

  rv_gpr rv_gpr_inst (
    .clk   (clk),
    .rst   (rst),
    .a_rs1 (ir.r.rs1),
    .a_rs2 (ir.r.rs2),
    .a_rd  (ir.r.rd),
    .e_rd  (gpr_we),
    .d_rd  (gpr_rd),
    .d_rs1 (gpr_rs1),
    .d_rs2 (gpr_rs2)
  );

  // operand muxes
  always_comb begin
    case (ctl.a1)
      A1_PC:   alu_rs1 = pc;
      A1_ZERO: alu_rs1 = '0;
      default: alu_rs1 = gpr_rs1;
    endcase
  end

  assign alu_rs2 = (ctl.a2 == A2_IMM) ? ctl.imm : gpr_rs2;

  rv_alu rv_alu_inst (
    .op  (ctl.ao),
    .rs1 (alu_rs1),
    .rs2 (alu_rs2),
    .rd  (alu_rd),
    .sum (alu_sum)
  );

  // compares registers, target comes from alu sum
  rv_br rv_br_inst (
    .op  (ctl.br),
    .rs1 (gpr_rs1),
    .rs2 (gpr_rs2),
    .tkn (br_tkn)
  );

  ////////////////////////////////////////////////////////////////////////////
  // load/store
  ////////////////////////////////////////////////////////////////////////////

  // request outputs held steady through MEM, ir and regs do not change
  assign ls_req = (state == S_MEM);
  assign ls_wen = (ctl.st != ST_NONE);
  assign ls_adr = alu_sum;

  // lane mask before alignment
  always_comb begin
    case (ctl.st)
      ST_B:    ls_mask = 4'b0001;
      ST_H:    ls_mask = 4'b0011;
      ST_W:    ls_mask = 4'b1111;
      default: begin
        // loads
        case (ctl.ld)
          LD_B, LD_BU: ls_mask = 4'b0001;
          LD_H, LD_HU: ls_mask = 4'b0011;
          default:     ls_mask = 4'b1111;
        endcase
      end
    endcase
  end

  assign ls_sel = ls_mask << ls_adr[1:0];

  // store data replicated across lanes
  always_comb begin
    case (ctl.st)
      ST_B:    ls_wdt = {4{gpr_rs2[7:0]}};
      ST_H:    ls_wdt = {2{gpr_rs2[15:0]}};
      default: ls_wdt = gpr_rs2;
    endcase
  end

  // load lane pick
  assign ld_b = ls_rdt[{ls_adr[1:0], 3'b000} +: 8];
  assign ld_h = ls_adr[1] ? ls_rdt[31:16] : ls_rdt[15:0];

  // sign or zero extension
  always_comb begin
    case (ctl.ld)
      LD_B:    ld_dat = {{24{ld_b[7]}}, ld_b};
      LD_BU:   ld_dat = {24'h000000, ld_b};
      LD_H:    ld_dat = {{16{ld_h[15]}}, ld_h};
      LD_HU:   ld_dat = {16'h0000, ld_h};
      default: ld_dat = ls_rdt;
    endcase
  end

endmodule

/* tests/rv_core_properties.sv */
`timescale 1ns/1ps

module rv_core_properties (
  input logic        clk,
  input logic        rst,
  input logic        if_req,
  input logic [31:0] if_adr,
  input logic        if_ack,
  input logic        ls_req,
  input logic        ls_wen,
  input logic [31:0] ls_adr,
  input logic [3:0]  ls_sel,
  input logic [31:0] ls_wdt,
  input logic        ls_ack
);

  // no bus activity while held in reset
  assert property (@(posedge clk) rst |-> (!if_req && !ls_req))
    else $error("bus request active during reset");

  // program bus request held until ack
  assert property (@(posedge clk) disable iff (rst)
    (if_req && !if_ack) |=> (if_req && $stable(if_adr)))
    else $error("program bus request changed before ack");

  // data bus request held until ack
  assert property (@(posedge clk) disable iff (rst)
    (ls_req && !ls_ack) |=> (ls_req && $stable(ls_wen) && $stable(ls_adr)
                             && $stable(ls_sel) && $stable(ls_wdt)))
    else $error("data bus request changed before ack");

  // one bus at a time
  assert property (@(posedge clk) disable iff (rst) !(if_req && ls_req))
    else $error("both bus requests high together");

  // a data access always enables some lane
  assert property (@(posedge clk) disable iff (rst) ls_req |-> (ls_sel != 4'b0000))
    else $error("data request with empty lane mask");

endmodule

bind rv_core rv_core_properties rv_core_properties_inst (.*);

/* tests/rv_core_tb.sv */
`timescale 1ns/1ps

module rv_core_tb;

  // opcodes and fixed addresses
  localparam int OP_LUI = 'h37;
  localparam int OP_AUIPC = 'h17;
  localparam int OP_JALR = 'h67;
  localparam int OP_IMM = 'h13;
  localparam int OP_LOAD = 'h03;
  localparam logic [31:0] END_ADR = 32'h3fc;

  logic        clk = 1'b0;
  logic        rst = 1'b1;
  logic        if_req;
  logic [31:0] if_adr;
  logic [31:0] if_rdt = '0;
  logic        if_ack = 1'b0;
  logic        ls_req;
  logic        ls_wen;
  logic [31:0] ls_adr;
  logic [3:0]  ls_sel;
  logic [31:0] ls_wdt;
  logic [31:0] ls_rdt = '0;
  logic        ls_ack = 1'b0;

  // memory models and store log
  logic [31:0] prog [256];
  logic [31:0] dmem [256];
  int          plen;
  int          if_cnt;
  int          ls_cnt;
  logic        wait_en = 1'b0;
  logic        end_seen = 1'b0;
  logic [31:0] lcg = 32'h7b656607;
  int          cycles = 0;
  int          cycle_limit = 0;
  logic [31:0] log_adr[$];
  logic [3:0]  log_sel[$];
  logic [31:0] log_dat[$];
  logic [31:0] exp_adr[$];
  logic [3:0]  exp_sel[$];
  logic [31:0] exp_dat[$];

  rv_core rv_core_inst (.*);

  always #5 clk = ~clk;

  ////////////////////////////////////////////////////////////////////////////
  // random numbers, bus models, timeout
  ////////////////////////////////////////////////////////////////////////////

  function automatic logic [31:0] lcg_next();
    lcg = lcg * 32'd1664525 + 32'd1013904223;
    return lcg;
  endfunction

  // 0..3 wait cycles when enabled
  function automatic int pick_wait();
    logic [31:0] r;
    r = lcg_next();
    return wait_en ? int'(r[17:16]) : 0;
  endfunction

  // fill depends on the whole word index
  function automatic logic [31:0] fill_word(int i);
    return (i + 1) * 32'h9e37_79b9;
  endfunction

  // program bus, ack held one cycle
  always @(negedge clk) begin
    if (rst || if_ack) begin
      if_ack <= 1'b0;
      if_cnt <= pick_wait();
    end else if (if_req) begin
      if (if_cnt == 0) begin
        if_ack <= 1'b1;
        if_rdt <= prog[if_adr[9:2]];
      end else begin
        if_cnt <= if_cnt - 1;
      end
    end
  end

  // data bus, write and log done here since the ack edge follows for sure
  always @(negedge clk) begin
    if (rst || ls_ack) begin
      ls_ack <= 1'b0;
      ls_cnt <= pick_wait();
    end else if (ls_req) begin
      if (ls_cnt == 0) begin
        ls_ack <= 1'b1;
        if (ls_wen) begin
          for (int k = 0; k < 4; k++) begin
            if (ls_sel[k]) dmem[ls_adr[9:2]][8*k +: 8] = ls_wdt[8*k +: 8];
          end
          log_adr.push_back(ls_adr);
          log_sel.push_back(ls_sel);
          log_dat.push_back(ls_wdt);
          if (ls_adr == END_ADR) end_seen <= 1'b1;
        end else begin
          ls_rdt <= dmem[ls_adr[9:2]];
        end
      end else begin
        ls_cnt <= ls_cnt - 1;
      end
    end
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles > cycle_limit) begin
      $display("timeout: program did not reach its final store in %0d cycles", cycle_limit);
      $display("FAIL: see errors above");
      $fatal(1);
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // encoders and program building
  ////////////////////////////////////////////////////////////////////////////

  function automatic logic [31:0] r_type(int f7, int rs2, int rs1, int f3, int rd);
    return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], 7'h33};
  endfunction

  function automatic logic [31:0] i_type(int imm, int rs1, int f3, int rd, int op);
    return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], op[6:0]};
  endfunction

  function automatic logic [31:0] s_type(int imm, int rs2, int rs1, int f3);
    return {imm[11:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:0], 7'h23};
  endfunction

  function automatic logic [31:0] b_type(int imm, int rs1, int rs2, int f3);
    return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:1], imm[11], 7'h63};
  endfunction

  function automatic logic [31:0] u_type(int imm20, int rd, int op);
    return {imm20[19:0], rd[4:0], op[6:0]};
  endfunction

  function automatic logic [31:0] j_type(int imm, int rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], 7'h6f};
  endfunction

  function automatic void emit(logic [31:0] w);
    prog[plen] = w;
    plen++;
  endfunction

  // empty program of nops, empty expectations, fresh data memory
  function automatic void new_program();
    for (int i = 0; i < 256; i++) begin
      prog[i] = 32'h0000_0013;
      dmem[i] = fill_word(i);
    end
    plen = 0;
    exp_adr.delete();
    exp_sel.delete();
    exp_dat.delete();
  endfunction

  // lui + addi, upper part rounded for the signed low part
  function automatic void load_const(int rd, logic [31:0] v);
    logic [31:0] hi;
    hi = (v + 32'h800) >> 12;
    emit(u_type(hi, rd, OP_LUI));
    emit(i_type(v[11:0], rd, 0, rd, OP_IMM));
  endfunction

  function automatic void expect_store(logic [31:0] adr, logic [3:0] sel, logic [31:0] dat);
    exp_adr.push_back(adr);
    exp_sel.push_back(sel);
    exp_dat.push_back(dat);
  endfunction

  // sw reg to adr, value known in advance
  function automatic void store_word(int rs2, logic [31:0] adr, logic [31:0] val);
    emit(s_type(adr, rs2, 0, 2));
    expect_store(adr, 4'hf, val);
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // run and check
  ////////////////////////////////////////////////////////////////////////////

  task automatic check_eq(string name, logic [31:0] exp, logic [31:0] act);
    assert (exp === act) else begin
      $display("[FAIL] %s: expected %h, actual %h", name, exp, act);
      $display("FAIL: see errors above");
      $fatal(1);
    end
  endtask

  // final store marks the end, then spin on jal x0, 0
  task automatic run_program();
    emit(s_type(END_ADR, 0, 0, 2));
    emit(j_type(0, 0));
    cycle_limit = cycle_limit + 20 * plen + 20;
    @(negedge clk);
    rst = 1'b1;
    log_adr.delete();
    log_sel.delete();
    log_dat.delete();
    end_seen = 1'b0;
    repeat (16) @(negedge clk);
    rst = 1'b0;
    while (!end_seen) @(negedge clk);
  endtask

  task automatic check_log(string name);
    assert (log_dat.size() == exp_dat.size() + 1) else begin
      $display("%s: store count %0d does not match %0d expected stores plus end marker",
               name, log_dat.size(), exp_dat.size());
      $display("FAIL: see errors above");
      $fatal(1);
    end
    for (int i = 0; i < exp_dat.size(); i++) begin
      check_eq({name, " adr"}, exp_adr[i], log_adr[i]);
      check_eq({name, " sel"}, {28'd0, exp_sel[i]}, {28'd0, log_sel[i]});
      check_eq({name, " data"}, exp_dat[i], log_dat[i]);
    end
  endtask

  // RV32I ALU rule, alt picks SUB and SRA
  function automatic logic [31:0] alu_rule(int f3, logic alt, logic [31:0] x, logic [31:0] y);
    case (f3)
      0: return alt ? x - y : x + y;
      1: return x << y[4:0];
      2: return ($signed(x) < $signed(y)) ? 1 : 0;
      3: return (x < y) ? 1 : 0;
      4: return x ^ y;
      5: return alt ? $unsigned($signed(x) >>> y[4:0]) : x >> y[4:0];
      6: return x | y;
      default: return x & y;
    endcase
  endfunction

  function automatic logic branch_rule(int f3, logic [31:0] x, logic [31:0] y);
    case (f3)
      0: return x == y;
      1: return x != y;
      4: return $signed(x) < $signed(y);
      5: return $signed(x) >= $signed(y);
      6: return x < y;
      default: return x >= y;
    endcase
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // directed tests
  ////////////////////////////////////////////////////////////////////////////

  task automatic test_alu(logic [31:0] a, logic [31:0] b, logic [31:0] imm);
    logic [31:0] immx;
    logic [31:0] out;
    int          sh;
    immx = {{20{imm[11]}}, imm[11:0]};
    sh = int'(imm[4:0]);
    out = 32'h100;
    new_program();
    load_const(1, a);
    load_const(2, b);
    // register-register, eight base plus SUB and SRA
    for (int f = 0; f < 8; f++) begin
      emit(r_type(0, 2, 1, f, 3));
      store_word(3, out, alu_rule(f, 1'b0, a, b));
      out += 4;
    end
    emit(r_type('h20, 2, 1, 0, 3));
    store_word(3, out, alu_rule(0, 1'b1, a, b));
    out += 4;
    emit(r_type('h20, 2, 1, 5, 3));
    store_word(3, out, alu_rule(5, 1'b1, a, b));
    out += 4;
    // immediate forms, shifts carry funct7 in imm[11:5]
    for (int f = 0; f < 8; f++) begin
      if (f == 1 || f == 5) begin
        emit(i_type(sh, 1, f, 3, OP_IMM));
        store_word(3, out, alu_rule(f, 1'b0, a, sh));
      end else begin
        emit(i_type(imm, 1, f, 3, OP_IMM));
        store_word(3, out, alu_rule(f, 1'b0, a, immx));
      end
      out += 4;
    end
    emit(i_type('h400 | sh, 1, 5, 3, OP_IMM));
    store_word(3, out, alu_rule(5, 1'b1, a, sh));
    run_program();
    check_log(wait_en ? "alu waits" : "alu");
  endtask

  task automatic test_x0();
    new_program();
    emit(i_type(123, 0, 0, 0, OP_IMM));
    store_word(0, 32'h100, 32'h0);
    run_program();
    check_log("x0");
  endtask

  task automatic test_flow();
    logic [31:0] xa[3];
    logic [31:0] xb[3];
    logic [31:0] out;
    logic [31:0] p;
    int          f3s[6];
    xa = '{32'hffff_fffd, 32'd7, 32'd9};
    xb = '{32'd7, 32'hffff_fffd, 32'd9};
    f3s = '{0, 1, 4, 5, 6, 7};
    out = 32'h100;
    new_program();
    emit(i_type('h11, 0, 0, 6, OP_IMM));
    emit(i_type('h22, 0, 0, 7, OP_IMM));
    // taken lands on the 0x22 store, fall-through stores 0x11 and jumps over
    for (int v = 0; v < 3; v++) begin
      load_const(1, xa[v]);
      load_const(2, xb[v]);
      for (int k = 0; k < 6; k++) begin
        emit(b_type(12, 1, 2, f3s[k]));
        emit(s_type(out, 6, 0, 2));
        emit(j_type(8, 0));
        emit(s_type(out, 7, 0, 2));
        expect_store(out, 4'hf, branch_rule(f3s[k], xa[v], xb[v]) ? 32'h22 : 32'h11);
        out += 4;
      end
    end
    // jal links past itself, skipped addi would clear the link
    p = plen * 4;
    emit(j_type(8, 9));
    emit(i_type(0, 0, 0, 9, OP_IMM));
    store_word(9, out, p + 4);
    out += 4;
    // jalr with odd target, bit 0 dropped
    p = plen * 4;
    emit(i_type(p + 12, 0, 0, 10, OP_IMM));
    emit(i_type(1, 10, 0, 11, OP_JALR));
    emit(i_type(0, 0, 0, 11, OP_IMM));
    store_word(11, out, p + 8);
    out += 4;
    p = plen * 4;
    emit(u_type('h12345, 12, OP_AUIPC));
    store_word(12, out, p + 32'h1234_5000);
    run_program();
    check_log("flow");
  endtask

  task automatic test_stores();
    logic [31:0] v;
    logic [31:0] adr;
    logic [3:0]  sel;
    logic [31:0] dat;
    logic [31:0] word;
    logic [3:0]  sels[7];
    logic [31:0] dats[7];
    v = 32'hc3b2_a190;
    new_program();
    load_const(5, v);
    // SB at offsets 0..3, SH at 0 and 2, SW, each into its own word
    for (int k = 0; k < 7; k++) begin
      adr = 32'h200 + 4 * k;
      if (k < 4) begin
        adr += k;
        sel = 4'b0001 << k;
        dat = {4{v[7:0]}};
        emit(s_type(adr, 5, 0, 0));
      end else if (k < 6) begin
        adr += 2 * (k - 4);
        sel = 4'b0011 << (2 * (k - 4));
        dat = {2{v[15:0]}};
        emit(s_type(adr, 5, 0, 1));
      end else begin
        sel = 4'hf;
        dat = v;
        emit(s_type(adr, 5, 0, 2));
      end
      expect_store(adr, sel, dat);
      sels[k] = sel;
      dats[k] = dat;
    end
    run_program();
    check_log("stores");
    // merged memory words
    for (int k = 0; k < 7; k++) begin
      word = fill_word(128 + k);
      for (int n = 0; n < 4; n++) begin
        if (sels[k][n]) word[8*n +: 8] = dats[k][8*n +: 8];
      end
      check_eq("stores merge", word, dmem[128 + k]);
    end
  endtask

  task automatic test_loads();
    logic [31:0] w;
    logic [31:0] out;
    logic [7:0]  b;
    logic [15:0] h;
    w = 32'h80f1_7f9c;
    out = 32'h300;
    new_program();
    dmem[160] = w;
    for (int o = 0; o < 4; o++) begin
      b = w[8*o +: 8];
      emit(i_type('h280 + o, 0, 0, 1, OP_LOAD));
      store_word(1, out, {{24{b[7]}}, b});
      emit(i_type('h280 + o, 0, 4, 1, OP_LOAD));
      store_word(1, out + 4, {24'd0, b});
      out += 8;
    end
    for (int o = 0; o < 4; o += 2) begin
      h = w[8*o +: 16];
      emit(i_type('h280 + o, 0, 1, 1, OP_LOAD));
      store_word(1, out, {{16{h[15]}}, h});
      emit(i_type('h280 + o, 0, 5, 1, OP_LOAD));
      store_word(1, out + 4, {16'd0, h});
      out += 8;
    end
    emit(i_type('h280, 0, 2, 1, OP_LOAD));
    store_word(1, out, w);
    run_program();
    check_log("loads");
  endtask

  initial begin
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] imm;
    // negative a against positive b, signed and unsigned compares disagree
    a = lcg_next() | 32'h8000_0000;
    b = lcg_next() & 32'h7fff_ffff;
    imm = lcg_next();
    test_alu(a, b, imm);
    test_x0();
    test_flow();
    test_stores();
    test_loads();
    // same alu program with random wait states on both buses
    wait_en = 1'b1;
    test_alu(a, b, imm);
    $display("PASS: all tests");
    $finish;
  end

endmodule

/* compile.f */
+incdir+include
design/rv_isa_pkg.sv
design/rv_decoder.sv
design/rv_gpr.sv
design/rv_alu.sv
design/rv_br.sv
design/rv_core.sv
tests/rv_core_properties.sv
tests/rv_core_tb.sv

/* Makefile */
VERILATOR = verilator
FLAGS     = --binary --timing --assert -j 0
TOP       = rv_core_tb
FILELIST  = compile.f
OBJDIR    = obj_dir
LOG       = sim.log
PASS_MSG  = PASS: all tests

.PHONY: sim clean

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJDIR)
	./$(OBJDIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)
